// File: rtl/adc_demux_pkg.sv
package adc_demux_pkg;

  // ADC geometry
  localparam int NUM_CH       = 4;
  localparam int NUM_LANES    = 2 * NUM_CH;
  localparam int WORD_W       = 10;
  localparam int BITS_PER_CLK = 2;
  localparam int WORD_CYCLES  = WORD_W / BITS_PER_CLK;

  // Frame lane carries five ones then five zeros every word
  localparam logic [WORD_W-1:0] FRAME_PATTERN = 10'b11111_00000;

  // Cycles from sync edge to FIFO read enable
  localparam int RD_DELAY = 11;

  // Frame buffering and downstream flow control
  localparam int FIFO_DEPTH = 16;
  localparam int CREDITS    = 4;

  // Register map
  localparam logic [31:0] REG_STATUS    = 32'h0000_0000;
  localparam logic [31:0] REG_FRAME_CNT = 32'h0000_0004;
  localparam logic [31:0] REG_ERR_CNT   = 32'h0000_0008;
  localparam logic [31:0] REG_BITSLIP   = 32'h0000_000C;
  localparam logic [31:0] REG_CTRL      = 32'h0000_0010;

  // One channel, two interleaved lanes
  typedef struct packed {
    logic [WORD_W-1:0] lane_a;
    logic [WORD_W-1:0] lane_b;
  } adc_ch_t;

  // All channels of one frame, 80 bits
  typedef struct packed {
    adc_ch_t [NUM_CH-1:0] ch;
  } adc_frame_t;

  // Wishbone master to slave
  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        we;
    logic        cyc;
    logic        stb;
  } wb_req_t;

  // Wishbone slave to master
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
    logic        err;
  } wb_rsp_t;

endpackage

// File: rtl/lane_deserializer.sv
`timescale 1ns/1ps

module lane_deserializer
  import adc_demux_pkg::*;
(
  input  logic                    fclk_ctr_clk,
  input  logic                    rst,
  input  logic [BITS_PER_CLK-1:0] bits_i,
  input  logic                    word_stb_i,
  input  logic                    slip_i,
  output logic [WORD_W-1:0]       word_o
);

  localparam int HIST_W = 2 * WORD_W;
  localparam int OFS_W  = $clog2(WORD_W);

  logic [HIST_W-1:0] hist_q;
  logic [HIST_W-1:0] hist_next;
  logic [OFS_W-1:0]  offset_q;

  // Rise bit is the earlier one, so it sits above the fall bit
  assign hist_next = {hist_q[HIST_W-BITS_PER_CLK-1:0], bits_i};

  // Bit history, oldest bit at the top
  always_ff @(posedge fclk_ctr_clk) begin
    hist_q <= hist_next;
  end

  // Slip offset, wraps after the last bit position
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      offset_q <= '0;
    end else if (slip_i) begin
      if (offset_q == OFS_W'(WORD_W - 1)) begin
        offset_q <= '0;
      end else begin
        offset_q <= offset_q + 1'b1;
      end
    end
  end

  // Window starts at the top of the history and moves down by the offset,
  // so a lane that lags by k bits lines up after k slips
  always_ff @(posedge fclk_ctr_clk) begin
    if (word_stb_i) begin
      word_o <= hist_next[(HIST_W - 1) - int'(offset_q) -: WORD_W];
    end
  end

endmodule

// File: rtl/frame_checker.sv
`timescale 1ns/1ps

module frame_checker
  import adc_demux_pkg::*;
(
  input  logic              fclk_ctr_clk,
  input  logic              rst,
  input  logic [WORD_W-1:0] frame_word_i,
  input  logic              clear_i,
  output logic              word_stb_o,
  output logic              word_rdy_o,
  output logic [31:0]       frame_cnt_o,
  output logic [31:0]       err_cnt_o
);

  localparam int PHASE_W = $clog2(WORD_CYCLES);

  logic [PHASE_W-1:0] phase_q;

  // Capture strobe on the last bit pair of a word
  assign word_stb_o = (phase_q == PHASE_W'(WORD_CYCLES - 1));

  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      phase_q <= '0;
    end else if (word_stb_o) begin
      phase_q <= '0;
    end else begin
      phase_q <= phase_q + 1'b1;
    end
  end

  // Words are valid one cycle after capture
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      word_rdy_o <= 1'b0;
    end else begin
      word_rdy_o <= word_stb_o;
    end
  end

  always_ff @(posedge fclk_ctr_clk) begin
    if (rst || clear_i) begin
      frame_cnt_o <= '0;
      err_cnt_o   <= '0;
    end else if (word_rdy_o) begin
      frame_cnt_o <= frame_cnt_o + 1'b1;
      // Misaligned or corrupted frame lane
      if (frame_word_i != FRAME_PATTERN) begin
        err_cnt_o <= err_cnt_o + 1'b1;
      end
    end
  end

endmodule

// File: rtl/sync_gate.sv
`timescale 1ns/1ps

module sync_gate
  import adc_demux_pkg::*;
(
  input  logic fclk_ctr_clk,
  input  logic rst,
  input  logic sync_i,
  output logic wr_en_o,
  output logic rd_en_o,
  output logic sync_o
);

  localparam int CNT_W = $clog2(RD_DELAY + 1);

  logic             sync_meta;
  logic             sync_sync;
  logic             sync_prev;
  logic             rd_pending;
  logic [CNT_W-1:0] rd_cnt;

  // Two-flop synchronizer, third flop for the edge
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      sync_meta <= 1'b0;
      sync_sync <= 1'b0;
      sync_prev <= 1'b0;
    end else begin
      sync_meta <= sync_i;
      sync_sync <= sync_meta;
      sync_prev <= sync_sync;
    end
  end

  assign sync_o = sync_sync & ~sync_prev;

  // Write side opens right after the edge and stays open
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      wr_en_o <= 1'b0;
    end else if (sync_o) begin
      wr_en_o <= 1'b1;
    end
  end

  // Read side opens RD_DELAY cycles after the edge
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      rd_pending <= 1'b0;
      rd_cnt     <= '0;
      rd_en_o    <= 1'b0;
    end else if (sync_o && !rd_pending && !rd_en_o) begin
      rd_pending <= 1'b1;
      rd_cnt     <= CNT_W'(RD_DELAY - 1);
    end else if (rd_pending) begin
      rd_cnt <= rd_cnt - 1'b1;
      if (rd_cnt == CNT_W'(1)) begin
        rd_pending <= 1'b0;
        rd_en_o    <= 1'b1;
      end
    end
  end

endmodule

// File: rtl/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo
  import adc_demux_pkg::*;
(
  input  logic       fclk_ctr_clk,
  input  logic       rst,
  input  adc_frame_t frame_i,
  input  logic       word_rdy_i,
  input  logic       wr_en_i,
  input  logic       rd_en_i,
  input  logic       clear_i,
  input  logic       credit_i,
  output adc_frame_t dout_o,
  output logic       dout_valid_o,
  output logic       overflow_o
);

  localparam int PTR_W  = $clog2(FIFO_DEPTH);
  localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
  localparam int CRED_W = $clog2(CREDITS + 1);

  adc_frame_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRED_W-1:0] credits;
  logic              push;
  logic              full;
  logic              empty;
  logic              do_wr;
  logic              do_rd;

  assign push  = word_rdy_i & wr_en_i;
  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);
  assign do_wr = push & ~full;
  // Pop only while the sink has room for another frame
  assign do_rd = rd_en_i & ~empty & (credits != '0);

  always_ff @(posedge fclk_ctr_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= frame_i;
    end
    if (do_rd) begin
      dout_o <= mem[rd_ptr];
    end
  end

  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      dout_valid_o <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      dout_valid_o <= do_rd;
    end
  end

  // One credit per returned pulse, one spent per frame sent
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      credits <= CRED_W'(CREDITS);
    end else begin
      credits <= credits + CRED_W'(credit_i) - CRED_W'(do_rd);
    end
  end

  // Sticky until cleared from the register bank
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst || clear_i) begin
      overflow_o <= 1'b0;
    end else if (push && full) begin
      overflow_o <= 1'b1;
    end
  end

endmodule

// File: rtl/wb_ctrl_regs.sv
`timescale 1ns/1ps

module wb_ctrl_regs
  import adc_demux_pkg::*;
(
  input  logic               fclk_ctr_clk,
  input  logic               rst,
  input  wb_req_t            wb_req_i,
  output wb_rsp_t            wb_rsp_o,
  input  logic [31:0]        frame_cnt_i,
  input  logic [31:0]        err_cnt_i,
  input  logic               overflow_i,
  input  logic               wr_en_i,
  input  logic               rd_en_i,
  output logic [NUM_LANES:0] bitslip_o,
  output logic               clear_o
);

  logic        ack_q;
  logic        err_q;
  logic [31:0] dat_q;
  logic        req;
  logic        hit;
  logic [31:0] rd_data;
  logic [31:0] byte_mask;
  logic [31:0] wr_data;

  // New request only once the previous one has been answered
  assign req = wb_req_i.cyc & wb_req_i.stb & ~ack_q & ~err_q;

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      byte_mask[8*b +: 8] = {8{wb_req_i.sel[b]}};
    end
  end

  assign wr_data = wb_req_i.dat & byte_mask;

  // Address decode and read mux
  always_comb begin
    hit     = 1'b1;
    rd_data = '0;
    case (wb_req_i.adr)
      REG_STATUS:    rd_data = {29'b0, rd_en_i, wr_en_i, overflow_i};
      REG_FRAME_CNT: rd_data = frame_cnt_i;
      REG_ERR_CNT:   rd_data = err_cnt_i;
      // Write-only pulse registers read back as zero
      REG_BITSLIP:   rd_data = '0;
      REG_CTRL:      rd_data = '0;
      default:       hit = 1'b0;
    endcase
  end

  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
      bitslip_o <= '0;
      clear_o   <= 1'b0;
    end else begin
      ack_q     <= req & hit;
      err_q     <= req & ~hit;
      bitslip_o <= '0;
      clear_o   <= 1'b0;
      if (req && hit && wb_req_i.we) begin
        // One slip pulse per bit written as one
        if (wb_req_i.adr == REG_BITSLIP) begin
          bitslip_o <= wr_data[NUM_LANES:0];
        end
        if (wb_req_i.adr == REG_CTRL) begin
          clear_o <= wr_data[0];
        end
      end
    end
  end

  always_ff @(posedge fclk_ctr_clk) begin
    if (req) begin
      dat_q <= rd_data;
    end
  end

  assign wb_rsp_o = '{dat: dat_q, ack: ack_q, err: err_q};

endmodule

// File: rtl/adc_demux_top.sv
`timescale 1ns/1ps

module adc_demux_top
  import adc_demux_pkg::*;
(
  input  logic                 fclk_ctr_clk,
  input  logic                 rst,
  input  logic                 sync_i,
  input  logic [NUM_LANES-1:0] data_rise_i,
  input  logic [NUM_LANES-1:0] data_fall_i,
  input  logic                 frame_rise_i,
  input  logic                 frame_fall_i,
  input  logic                 credit_i,
  output adc_frame_t           dout_o,
  output logic                 dout_valid_o,
  output logic                 sync_o,
  input  logic [31:0]          wb_adr_i,
  input  logic [31:0]          wb_dat_i,
  input  logic [3:0]           wb_sel_i,
  input  logic                 wb_we_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  output logic [31:0]          wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o
);

  wb_req_t            wb_req;
  wb_rsp_t            wb_rsp;
  logic [WORD_W-1:0]  lane_word [NUM_LANES];
  logic [WORD_W-1:0]  frame_word;
  logic [NUM_LANES:0] bitslip;
  adc_frame_t         frame;
  logic               word_stb;
  logic               word_rdy;
  logic               clear;
  logic               wr_en;
  logic               rd_en;
  logic               overflow;
  logic [31:0]        frame_cnt;
  logic [31:0]        err_cnt;

  assign wb_req   = '{adr: wb_adr_i, dat: wb_dat_i, sel: wb_sel_i,
                      we: wb_we_i, cyc: wb_cyc_i, stb: wb_stb_i};
  assign wb_dat_o = wb_rsp.dat;
  assign wb_ack_o = wb_rsp.ack;
  assign wb_err_o = wb_rsp.err;

  // Data lanes
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    lane_deserializer u_lane (
      .fclk_ctr_clk (fclk_ctr_clk),
      .rst          (rst),
      .bits_i       ({data_rise_i[l], data_fall_i[l]}),
      .word_stb_i   (word_stb),
      .slip_i       (bitslip[l]),
      .word_o       (lane_word[l])
    );
  end

  // Frame lane takes the top slip bit
  lane_deserializer u_frame_lane (
    .fclk_ctr_clk (fclk_ctr_clk),
    .rst          (rst),
    .bits_i       ({frame_rise_i, frame_fall_i}),
    .word_stb_i   (word_stb),
    .slip_i       (bitslip[NUM_LANES]),
    .word_o       (frame_word)
  );

  // Lane 2c is lane_a and lane 2c+1 is lane_b of channel c
  for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
    assign frame.ch[c].lane_a = lane_word[2*c];
    assign frame.ch[c].lane_b = lane_word[2*c+1];
  end

  frame_checker u_frame_checker (
    .fclk_ctr_clk (fclk_ctr_clk),
    .rst          (rst),
    .frame_word_i (frame_word),
    .clear_i      (clear),
    .word_stb_o   (word_stb),
    .word_rdy_o   (word_rdy),
    .frame_cnt_o  (frame_cnt),
    .err_cnt_o    (err_cnt)
  );

  sync_gate u_sync_gate (
    .fclk_ctr_clk (fclk_ctr_clk),
    .rst          (rst),
    .sync_i       (sync_i),
    .wr_en_o      (wr_en),
    .rd_en_o      (rd_en),
    .sync_o       (sync_o)
  );

  sample_fifo u_sample_fifo (
    .fclk_ctr_clk (fclk_ctr_clk),
    .rst          (rst),
    .frame_i      (frame),
    .word_rdy_i   (word_rdy),
    .wr_en_i      (wr_en),
    .rd_en_i      (rd_en),
    .clear_i      (clear),
    .credit_i     (credit_i),
    .dout_o       (dout_o),
    .dout_valid_o (dout_valid_o),
    .overflow_o   (overflow)
  );

  wb_ctrl_regs u_wb_ctrl_regs (
    .fclk_ctr_clk (fclk_ctr_clk),
    .rst          (rst),
    .wb_req_i     (wb_req),
    .wb_rsp_o     (wb_rsp),
    .frame_cnt_i  (frame_cnt),
    .err_cnt_i    (err_cnt),
    .overflow_i   (overflow),
    .wr_en_i      (wr_en),
    .rd_en_i      (rd_en),
    .bitslip_o    (bitslip),
    .clear_o      (clear)
  );

endmodule

// File: tb/tb_adc_demux.sv
`timescale 1ns/1ps

module tb_adc_demux
  import adc_demux_pkg::*;
();

  localparam int NUM_TESTS = 4;
  localparam int LAG_LANE  = 3;
  localparam int MAX_WORDS = 32;
  localparam int WAIT_MAX  = 3000;

  logic fclk_ctr_clk = 1'b0;
  logic rst = 1'b1;
  logic sync_i = 1'b0;
  logic [NUM_LANES-1:0] data_rise_i = '0;
  logic [NUM_LANES-1:0] data_fall_i = '0;
  logic frame_rise_i = 1'b0;
  logic frame_fall_i = 1'b0;
  logic credit_i = 1'b0;
  adc_frame_t dout_o;
  logic dout_valid_o;
  logic sync_o;
  logic [31:0] wb_adr_i = '0;
  logic [31:0] wb_dat_i = '0;
  logic [3:0] wb_sel_i = '0;
  logic wb_we_i = 1'b0;
  logic wb_cyc_i = 1'b0;
  logic wb_stb_i = 1'b0;
  logic [31:0] wb_dat_o;
  logic wb_ack_o;
  logic wb_err_o;

  // Stimulus table
  string t_name       [NUM_TESTS] = '{"basic", "frame_err", "bitslip", "backpressure"};
  int    t_lag        [NUM_TESTS] = '{0, 0, 3, 0};
  int    t_slips      [NUM_TESTS] = '{0, 0, 3, 0};
  int    t_frames     [NUM_TESTS] = '{24, 24, 24, 24};
  int    t_credit_ret [NUM_TESTS] = '{1, 1, 1, 0};
  int    t_errs       [NUM_TESTS] = '{0, 3, 0, 0};

  logic [WORD_W-1:0] words [MAX_WORDS][NUM_LANES+1];
  adc_frame_t outq [$];
  integer seed = 32'h63c1;
  int rst_left = 3;
  int cyc_n = 0;
  int nw_cur = 0;
  int lag_cur = 0;
  int release_n = 0;
  int sync_pulses = 0;
  logic hold = 1'b0;

  adc_demux_top DUT (.*);

  always #50 fclk_ctr_clk = ~fclk_ctr_clk;

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  // Addresses that the register map defines
  function automatic logic reg_mapped(logic [31:0] adr);
    return adr inside {REG_STATUS, REG_FRAME_CNT, REG_ERR_CNT, REG_BITSLIP, REG_CTRL};
  endfunction

  // Bit i of a lane's serial stream, MSB of each word first
  function automatic logic stream_bit(int l, int i);
    int j;
    j = (l == LAG_LANE) ? i - lag_cur : i;
    if (j < 0) return 1'b0;
    if (j >= WORD_W * nw_cur) begin
      // Idle frame lane keeps the pattern going
      return (l == NUM_LANES) ? FRAME_PATTERN[WORD_W - 1 - j % WORD_W] : 1'b0;
    end
    return words[j / WORD_W][l][WORD_W - 1 - j % WORD_W];
  endfunction

  // Reset sequencer and lane serializer
  always @(negedge fclk_ctr_clk) begin
    logic b_hi;
    logic b_lo;
    if (rst_left > 0) begin
      rst = 1'b1;
      sync_i = 1'b0;
      rst_left--;
      cyc_n = 0;
    end else begin
      rst = 1'b0;
      for (int l = 0; l <= NUM_LANES; l++) begin
        b_hi = stream_bit(l, 2 * cyc_n);
        b_lo = stream_bit(l, 2 * cyc_n + 1);
        if (l == NUM_LANES) begin
          frame_rise_i = b_hi;
          frame_fall_i = b_lo;
        end else begin
          data_rise_i[l] = b_hi;
          data_fall_i[l] = b_lo;
        end
      end
      sync_i = (cyc_n >= 2 * WORD_CYCLES);
      cyc_n++;
    end
  end

  // Output monitor and credit sink
  always @(negedge fclk_ctr_clk) begin
    if (dout_valid_o) outq.push_back(dout_o);
    if (sync_o) sync_pulses++;
    if (release_n > 0) begin
      credit_i = 1'b1;
      release_n--;
    end else begin
      credit_i = dout_valid_o && !hold;
    end
  end

  task automatic wb_access(logic [31:0] adr, logic we, logic [31:0] dat,
                           output logic [31:0] rdata, output logic err);
    int t;
    t = 0;
    @(negedge fclk_ctr_clk);
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = 4'hF;
    wb_we_i = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    do begin
      @(negedge fclk_ctr_clk);
      t++;
      if (t > 20) abort_run("Wishbone access got neither ack nor err");
    end while (!wb_ack_o && !wb_err_o);
    rdata = wb_dat_o;
    err = wb_err_o;
    check_value("wb response latency", 32'd1, t);
    check_value("wb ack", 32'(reg_mapped(adr)), 32'(wb_ack_o));
    check_value("wb err", 32'(!reg_mapped(adr)), 32'(wb_err_o));
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
  endtask

  task automatic wait_outputs(int n);
    int t;
    t = 0;
    while (outq.size() < n) begin
      @(posedge fclk_ctr_clk);
      t++;
      if (t > WAIT_MAX) abort_run("timeout waiting for output frames");
    end
  endtask

  task automatic wait_stream_cycle(int c);
    int t;
    t = 0;
    while (cyc_n < c) begin
      @(posedge fclk_ctr_clk);
      t++;
      if (t > WAIT_MAX) abort_run("timeout waiting for the serial stream to finish");
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic err;
    int n_exp;
    int skip;
    logic [WORD_W-1:0] exp_w;
    logic [WORD_W-1:0] act_w;
    for (int t = 0; t < NUM_TESTS; t++) begin
      nw_cur = t_frames[t];
      for (int w = 0; w < nw_cur; w++) begin
        for (int l = 0; l < NUM_LANES; l++) words[w][l] = WORD_W'($random(seed));
        // Corrupted frame words sit at the end of the stream
        words[w][NUM_LANES] = (w >= nw_cur - t_errs[t]) ? FRAME_PATTERN ^ 10'h001
                                                        : FRAME_PATTERN;
      end
      @(posedge fclk_ctr_clk);
      lag_cur = t_lag[t];
      hold = (t_credit_ret[t] == 0);
      rst_left = 3;
      repeat (5) @(posedge fclk_ctr_clk);
      outq.delete();
      sync_pulses = 0;
      wait_outputs(1);
      wb_access(REG_CTRL, 1'b1, 32'd1, rd, err);
      wb_access(REG_FRAME_CNT, 1'b0, 32'd0, rd, err);
      check_value({t_name[t], " frame count after clear"}, 32'd0, rd);
      wb_access(REG_ERR_CNT, 1'b0, 32'd0, rd, err);
      check_value({t_name[t], " error count after clear"}, 32'd0, rd);
      skip = 0;
      if (t_slips[t] > 0) begin
        check_value({t_name[t], " lagged lane before slip"}, 32'd1,
                    32'(outq[0].ch[LAG_LANE / 2].lane_b != words[1][LAG_LANE]));
        for (int k = 0; k < t_slips[t]; k++) begin
          wb_access(REG_BITSLIP, 1'b1, 32'd1 << LAG_LANE, rd, err);
        end
        skip = outq.size() + 2;
      end
      wait_stream_cycle(WORD_CYCLES * nw_cur + 2 * WORD_CYCLES);
      check_value({t_name[t], " sync pulses"}, 32'd1, sync_pulses);
      wb_access(REG_STATUS, 1'b0, 32'd0, rd, err);
      check_value({t_name[t], " status enables"}, 32'd3, 32'(rd[2:1]));
      if (hold) begin
        check_value({t_name[t], " frames out with credits withheld"}, CREDITS, outq.size());
        check_value({t_name[t], " overflow flag"}, 32'd1, 32'(rd[0]));
        @(posedge fclk_ctr_clk);
        release_n = FIFO_DEPTH;
        n_exp = CREDITS + FIFO_DEPTH;
      end else begin
        check_value({t_name[t], " overflow flag"}, 32'd0, 32'(rd[0]));
        n_exp = nw_cur - 1;
      end
      wait_outputs(n_exp);
      // Output i carries serialized word i+1
      for (int i = 0; i < n_exp; i++) begin
        for (int l = 0; l < NUM_LANES; l++) begin
          act_w = (l % 2 == 0) ? outq[i].ch[l / 2].lane_a : outq[i].ch[l / 2].lane_b;
          exp_w = words[i + 1][l];
          if (!(l == LAG_LANE && i < skip)) begin
            check_value($sformatf("%s frame %0d lane %0d", t_name[t], i, l),
                        32'(exp_w), 32'(act_w));
          end
        end
      end
      wb_access(REG_ERR_CNT, 1'b0, 32'd0, rd, err);
      check_value({t_name[t], " error count"}, t_errs[t], rd);
      wb_access(REG_FRAME_CNT, 1'b0, 32'd0, rd, err);
      check_value({t_name[t], " frame count"}, 32'd1, 32'(rd >= 32'(t_frames[t] - 8)));
    end
    wb_access(32'h0000_0020, 1'b0, 32'd0, rd, err);
    check_value("unmapped address err", 32'd1, 32'(err));
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: adc_demux.f
rtl/adc_demux_pkg.sv
rtl/lane_deserializer.sv
rtl/frame_checker.sv
rtl/sync_gate.sv
rtl/sample_fifo.sv
rtl/wb_ctrl_regs.sv
rtl/adc_demux_top.sv
tb/tb_adc_demux.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ADC demux testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_adc_demux \
  -f adc_demux.f -o sim_adc_demux > build.log 2>&1 \
  && ./obj_dir/sim_adc_demux > sim.log 2>&1

grep -F -q "*** PASSED ***" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
